//--- build.f
common/memPkg.sv
common/instPkg.sv
memctrl/memCtrl.sv
verilog/byteRam.sv
verilog/fetchUnit.sv
verilog/instQueue.sv
verilog/instDecode.sv
verilog/memTop.sv
tests/memTb.sv

//--- common/instPkg.sv
package instPkg;

    localparam logic [6:0] OP_LOAD  = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iFmtT;

    // store immediate is split around rs2 and rs1
    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sFmtT;

    typedef union packed {
        iFmtT i;
        sFmtT s;
    } instU;

    typedef enum logic [1:0] {
        CLASS_OTHER,
        CLASS_LOAD,
        CLASS_STORE
    } instClassT;

    // one queue slot
    typedef struct packed {
        memPkg::addrT pc;
        instU         word;
    } fetchEntryT;

    typedef struct packed {
        memPkg::addrT pc;
        instU         word;
        instClassT    instClass;
        logic [31:0]  imm;
    } decodedT;

endpackage

//--- common/memPkg.sv
package memPkg;

    typedef logic [31:0] addrT;

    // bytes per transfer, only 1, 2 and 4 are legal
    typedef logic [2:0] lenT;

    // data port request, held until done
    typedef struct packed {
        logic        en;
        logic        store;
        lenT         len;
        addrT        addr;
        logic [31:0] wdata;
    } dataReqT;

    typedef struct packed {
        logic        done;
        logic [31:0] rdata;
    } dataRespT;

    typedef struct packed {
        logic en;
        addrT addr;
    } fetchReqT;

    typedef struct packed {
        logic        done;
        logic [31:0] word;
    } fetchRespT;

endpackage

//--- memctrl/memCtrl.sv
`timescale 1ns/100ps

module memCtrl #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stall,
    input  memPkg::dataReqT       dataReq,
    input  memPkg::fetchReqT      fetchReq,
    input  logic [7:0]            ramRdata,
    output memPkg::dataRespT      dataResp,
    output memPkg::fetchRespT     fetchResp,
    output logic [ADDR_WIDTH-1:0] ramAddr,
    output logic                  ramWe,
    output logic [7:0]            ramWdata
);

    logic [2:0]   stage;
    logic         ownerFetch;
    logic [23:0]  asmBytes;
    logic         busy;
    logic         active;
    logic         advance;
    logic         curFetch;
    logic         curStore;
    memPkg::lenT  curLen;
    logic [2:0]   lastIdx;
    logic [2:0]   doneStage;
    logic [2:0]   offset;
    logic         atDone;
    memPkg::addrT base;
    memPkg::addrT byteAddr;
    logic [31:0]  loadWord;

    assign busy    = (stage != 3'd0);
    assign active  = busy || dataReq.en || fetchReq.en;
    assign advance = active && !stall;

    // owner is latched when a request is taken and data wins a tie
    assign curFetch = busy ? ownerFetch : !dataReq.en;
    assign curStore = !curFetch && dataReq.store;
    assign curLen   = curFetch ? 3'd4 : dataReq.len;
    assign lastIdx  = curLen - 3'd1;

    // stores finish on the stage after their last write and loads one stage later
    always_comb begin
        if (curFetch) begin
            doneStage = 3'd5;
        end else if (curStore) begin
            doneStage = curLen;
        end else begin
            doneStage = curLen + 3'd1;
        end
    end

    assign atDone = busy && (stage == doneStage);

    // under stall the previous byte is read again, so ramRdata
    // still shows the byte owed to this stage when it resumes
    always_comb begin
        offset = (stall && busy) ? stage - 3'd1 : stage;
        if (offset > lastIdx) begin
            offset = lastIdx;
        end
    end

    assign base     = curFetch ? fetchReq.addr : dataReq.addr;
    assign byteAddr = base + {29'd0, offset};
    assign ramAddr  = active ? byteAddr[ADDR_WIDTH-1:0] : '0;
    assign ramWe    = advance && curStore && (stage < curLen);
    assign ramWdata = dataReq.wdata[{stage[1:0], 3'b000} +: 8];

    // zero-extended load with the last byte straight from the RAM
    always_comb begin
        case (dataReq.len)
            3'd1:    loadWord = {24'd0, ramRdata};
            3'd2:    loadWord = {16'd0, ramRdata, asmBytes[7:0]};
            default: loadWord = {ramRdata, asmBytes};
        endcase
    end

    always_comb begin
        dataResp.done  = atDone && !stall && !ownerFetch;
        dataResp.rdata = loadWord;
        fetchResp.done = atDone && !stall && ownerFetch;
        fetchResp.word = {ramRdata, asmBytes};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stage      <= 3'd0;
            ownerFetch <= 1'b0;
        end else if (advance) begin
            if (!busy) begin
                ownerFetch <= !dataReq.en;
            end
            stage <= atDone ? 3'd0 : stage + 3'd1;
        end
    end

    // byte k-1 lands in stage k in little-endian order
    always_ff @(posedge clk) begin
        if (advance && busy && !curStore && stage <= 3'd3) begin
            asmBytes[{stage[1:0] - 2'd1, 3'b000} +: 8] <= ramRdata;
        end
    end

    // each done is a single-cycle pulse
    assert property (@(posedge clk) disable iff (rst)
        (dataResp.done || fetchResp.done) |=> !(dataResp.done || fetchResp.done));

    assert property (@(posedge clk) disable iff (rst)
        dataReq.en |-> (dataReq.len inside {3'd1, 3'd2, 3'd4}));

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module memTb -o memTb
./obj_dir/memTb | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- tests/memTb.sv
`timescale 1ns/100ps

module memTb;

    localparam int           ADDR_WIDTH  = 10;
    localparam int           QUEUE_DEPTH = 4;
    localparam memPkg::addrT START_PC    = 32'h100;
    localparam int           MEM_SIZE    = 2**ADDR_WIDTH;
    localparam int           PROG_WORDS  = 64;
    localparam int           TIMEOUT     = 100;

    logic             clk;
    logic             rst;
    memPkg::dataReqT  dataReq;
    logic             stall;
    logic             runEn;
    logic             take;
    memPkg::dataRespT dataResp;
    instPkg::decodedT decoded;
    logic             decodedValid;

    logic [31:0]  lfsr;
    logic [7:0]   refMem [MEM_SIZE];
    memPkg::addrT nextPc;

    memTop #(
        .ADDR_WIDTH  (ADDR_WIDTH),
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .START_PC    (START_PC)
    ) uut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] randBits(int n);
        logic [31:0] val;
        val = '0;
        for (int k = 0; k < n; k++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h80200003 : 32'h0);
        end
        return val;
    endfunction

    // upper address bits fall away, as in the RAM
    function automatic logic [ADDR_WIDTH-1:0] memIndex(memPkg::addrT addr);
        return addr[ADDR_WIDTH-1:0];
    endfunction

    function automatic void modelStore(memPkg::addrT addr, memPkg::lenT len, logic [31:0] wdata);
        for (int k = 0; k < int'(len); k++) begin
            refMem[memIndex(addr + 32'(k))] = wdata[8*k +: 8];
        end
    endfunction

    function automatic logic [31:0] modelLoad(memPkg::addrT addr, memPkg::lenT len);
        logic [31:0] val;
        val = '0;
        for (int k = 0; k < int'(len); k++) begin
            val[8*k +: 8] = refMem[memIndex(addr + 32'(k))];
        end
        return val;
    endfunction

    function automatic instPkg::decodedT expectDecoded(memPkg::addrT pc);
        instPkg::decodedT want;
        logic [31:0]      word;
        word      = modelLoad(pc, 3'd4);
        want.pc   = pc;
        want.word = word;
        want.imm  = {{20{word[31]}}, word[31:20]};
        if (word[6:0] == instPkg::OP_LOAD) begin
            want.instClass = instPkg::CLASS_LOAD;
        end else if (word[6:0] == instPkg::OP_STORE) begin
            want.instClass = instPkg::CLASS_STORE;
            want.imm       = {{20{word[31]}}, word[31:25], word[11:7]};
        end else begin
            want.instClass = instPkg::CLASS_OTHER;
        end
        return want;
    endfunction

    function automatic logic [31:0] randomInst();
        logic [1:0]  pick;
        logic [24:0] fields;
        logic [6:0]  opcode;
        pick   = 2'(randBits(2));
        fields = 25'(randBits(25));
        case (pick)
            2'd0:    opcode = instPkg::OP_LOAD;
            2'd1:    opcode = instPkg::OP_STORE;
            default: opcode = 7'b0010011;
        endcase
        return {fields, opcode};
    endfunction

    task automatic failRun(string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkData(string name, memPkg::dataRespT want, memPkg::dataRespT got);
        if (got !== want) begin
            failRun($sformatf("Error %s: expected %h, actual %h", name, want, got));
        end
    endtask

    task automatic checkDecoded(string name, instPkg::decodedT want, instPkg::decodedT got);
        if (got !== want) begin
            failRun($sformatf("Error %s: expected %h, actual %h", name, want, got));
        end
    endtask

    task automatic checkCycles(string name, int want, int got);
        if (got != want) begin
            failRun($sformatf("Error %s: expected %0d, actual %0d", name, want, got));
        end
    endtask

    // one data request, cycles count from the cycle enable goes up
    task automatic dataAccess(input string name, input logic store, input memPkg::lenT len,
                              input memPkg::addrT addr, input logic [31:0] wdata,
                              input int stallLen, output memPkg::dataRespT resp,
                              output int cycles);
        @(negedge clk);
        dataReq.en    = 1'b1;
        dataReq.store = store;
        dataReq.len   = len;
        dataReq.addr  = addr;
        dataReq.wdata = wdata;
        stall         = 1'b0;
        cycles        = 0;
        #1;
        while (!dataResp.done) begin
            @(negedge clk);
            cycles++;
            stall = (cycles <= stallLen);
            #1;
            if (stall && dataResp.done) begin
                failRun($sformatf("%s: done pulsed while stall was high", name));
            end
            if (cycles > TIMEOUT + stallLen) begin
                failRun($sformatf("%s: data request never completed", name));
            end
        end
        resp = dataResp;
        @(negedge clk);
        dataReq.en = 1'b0;
        stall      = 1'b0;
    endtask

    // keeps take high until count instructions have popped
    task automatic takeMany(string name, int count);
        int taken;
        int waited;
        taken  = 0;
        waited = 0;
        while (taken < count) begin
            @(negedge clk);
            take = 1'b1;
            #1;
            if (decodedValid) begin
                checkDecoded(name, expectDecoded(nextPc), decoded);
                nextPc += 4;
                taken++;
                waited = 0;
            end else if (waited == TIMEOUT) begin
                failRun($sformatf("%s: no instruction arrived at the decoder", name));
            end else begin
                waited++;
            end
        end
        @(negedge clk);
        take = 1'b0;
    endtask

    task automatic testStoreLoad();
        memPkg::lenT      len;
        memPkg::addrT     addr;
        logic [31:0]      wdata;
        memPkg::dataRespT resp;
        memPkg::dataRespT want;
        int               cycles;
        for (int r = 0; r < 12; r++) begin
            len   = (r % 3 == 0) ? 3'd1 : (r % 3 == 1) ? 3'd2 : 3'd4;
            addr  = randBits(12);
            wdata = randBits(32);
            dataAccess("storeLoad", 1'b1, len, addr, wdata, 0, resp, cycles);
            modelStore(addr, len, wdata);
            checkCycles("storeTiming", int'(len), cycles);
            dataAccess("storeLoad", 1'b0, len, addr, 32'h0, 0, resp, cycles);
            checkCycles("loadTiming", int'(len) + 1, cycles);
            want.done  = 1'b1;
            want.rdata = modelLoad(addr, len);
            checkData("storeLoad", want, resp);
        end
    endtask

    task automatic testStall();
        memPkg::lenT      len;
        memPkg::addrT     addr;
        memPkg::dataRespT resp;
        memPkg::dataRespT want;
        int               cycles;
        int               stallLen;
        for (int r = 0; r < 6; r++) begin
            len      = (r % 3 == 0) ? 3'd4 : (r % 3 == 1) ? 3'd1 : 3'd2;
            addr     = randBits(12);
            stallLen = 1 + int'(randBits(3));
            dataAccess("stall", 1'b1, 3'd4, addr, randBits(32), 0, resp, cycles);
            modelStore(addr, 3'd4, dataReq.wdata);
            dataAccess("stall", 1'b0, len, addr, 32'h0, stallLen, resp, cycles);
            checkCycles("stallTiming", int'(len) + 1 + stallLen, cycles);
            want.done  = 1'b1;
            want.rdata = modelLoad(addr, len);
            checkData("stall", want, resp);
        end
    endtask

    task automatic testFetch();
        memPkg::addrT     addr;
        logic [31:0]      word;
        memPkg::dataRespT resp;
        int               cycles;
        for (int i = 0; i < PROG_WORDS; i++) begin
            addr = START_PC + 32'(4 * i);
            word = randomInst();
            dataAccess("program", 1'b1, 3'd4, addr, word, 0, resp, cycles);
            modelStore(addr, 3'd4, word);
        end
        @(negedge clk);
        runEn = 1'b1;
        takeMany("fetch", 12);
    endtask

    task automatic testBackPressure();
        int waited;
        waited = 0;
        @(negedge clk);
        #1;
        while (!decodedValid) begin
            if (waited == TIMEOUT) begin
                failRun("backPressure: queue stayed empty");
            end
            waited++;
            @(negedge clk);
            #1;
        end
        // long enough for the queue to fill up
        repeat (40) @(negedge clk);
        for (int i = 0; i < 10; i++) begin
            takeMany("backPressure", 1);
        end
    endtask

    task automatic testPriority();
        memPkg::addrT     addr;
        logic [31:0]      wdata;
        memPkg::dataRespT resp;
        memPkg::dataRespT want;
        int               cycles;
        takeMany("priority", 3);
        // top quarter of the RAM, away from the program
        addr  = {22'h0, 2'b11, 8'(randBits(8))};
        wdata = randBits(32);
        dataAccess("priority", 1'b1, 3'd4, addr, wdata, 0, resp, cycles);
        modelStore(addr, 3'd4, wdata);
        dataAccess("priority", 1'b0, 3'd4, addr, 32'h0, 0, resp, cycles);
        want.done  = 1'b1;
        want.rdata = modelLoad(addr, 3'd4);
        checkData("priority", want, resp);
        takeMany("priority", 8);
    endtask

    initial begin
        lfsr    = 32'hf6fb;
        rst     = 1'b1;
        dataReq = '0;
        stall   = 1'b0;
        runEn   = 1'b0;
        take    = 1'b0;
        nextPc  = START_PC;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        testStoreLoad();
        testStall();
        testFetch();
        testBackPressure();
        testPriority();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- verilog/byteRam.sv
`timescale 1ns/100ps

module byteRam #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic                  clk,
    input  logic [ADDR_WIDTH-1:0] addr,
    input  logic                  we,
    input  logic [7:0]            wdata,
    output logic [7:0]            rdata
);

    // index is already cut down to ADDR_WIDTH bits by the controller
    logic [7:0] mem [2**ADDR_WIDTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        // old contents on a same-cycle write
        rdata <= mem[addr];
    end

endmodule

//--- verilog/fetchUnit.sv
`timescale 1ns/100ps

module fetchUnit #(
    parameter memPkg::addrT START_PC = 32'h0
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                runEn,
    input  logic                queueFull,
    input  memPkg::fetchRespT   fetchResp,
    output memPkg::fetchReqT    fetchReq,
    output logic                push,
    output instPkg::fetchEntryT pushEntry
);

    memPkg::addrT pc;
    logic         busy;

    // once raised the request stays up until the word comes back
    always_comb begin
        fetchReq.en   = busy || (runEn && !queueFull);
        fetchReq.addr = pc;
    end

    assign push = fetchResp.done;

    always_comb begin
        pushEntry.pc   = pc;
        pushEntry.word = fetchResp.word;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc   <= START_PC;
            busy <= 1'b0;
        end else begin
            busy <= fetchReq.en && !fetchResp.done;
            if (fetchResp.done) begin
                pc <= pc + 32'd4;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) push |-> !queueFull);

endmodule

//--- verilog/instDecode.sv
`timescale 1ns/100ps

module instDecode (
    input  instPkg::fetchEntryT head,
    input  logic                empty,
    input  logic                take,
    output logic                pop,
    output instPkg::decodedT    decoded,
    output logic                decodedValid
);

    instPkg::instU word;

    assign word         = head.word;
    assign decodedValid = !empty;
    assign pop          = take && !empty;

    always_comb begin
        decoded.pc   = head.pc;
        decoded.word = word;
        case (word.i.opcode)
            instPkg::OP_LOAD:  decoded.instClass = instPkg::CLASS_LOAD;
            instPkg::OP_STORE: decoded.instClass = instPkg::CLASS_STORE;
            default:           decoded.instClass = instPkg::CLASS_OTHER;
        endcase
        // S view only for stores
        if (decoded.instClass == instPkg::CLASS_STORE) begin
            decoded.imm = {{20{word.s.immHi[6]}}, word.s.immHi, word.s.immLo};
        end else begin
            decoded.imm = {{20{word.i.imm[11]}}, word.i.imm};
        end
    end

endmodule

//--- verilog/instQueue.sv
`timescale 1ns/100ps

module instQueue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                push,
    input  instPkg::fetchEntryT pushEntry,
    input  logic                pop,
    output instPkg::fetchEntryT head,
    output logic                empty,
    output logic                full
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    instPkg::fetchEntryT entries [QUEUE_DEPTH];
    logic [PTR_W-1:0]    wrPtr;
    logic [PTR_W-1:0]    rdPtr;
    logic [PTR_W:0]      count;

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wrPtr] <= pushEntry;
        end
    end

    // pointers wrap on their own since depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + PTR_W'(1);
            end
            if (pop) begin
                rdPtr <= rdPtr + PTR_W'(1);
            end
            count <= count + {{PTR_W{1'b0}}, push} - {{PTR_W{1'b0}}, pop};
        end
    end

    assign head  = entries[rdPtr];
    assign empty = (count == '0);
    assign full  = (count == (PTR_W + 1)'(QUEUE_DEPTH));

    assert property (@(posedge clk) disable iff (rst) pop |-> !empty);

endmodule

//--- verilog/memTop.sv
`timescale 1ns/100ps

module memTop #(
    parameter int           ADDR_WIDTH  = 10,
    parameter int           QUEUE_DEPTH = 4,
    parameter memPkg::addrT START_PC    = 32'h0
) (
    input  logic              clk,
    input  logic              rst,
    input  memPkg::dataReqT   dataReq,
    input  logic              stall,
    input  logic              runEn,
    input  logic              take,
    output memPkg::dataRespT  dataResp,
    output instPkg::decodedT  decoded,
    output logic              decodedValid
);

    memPkg::fetchReqT      fetchReq;
    memPkg::fetchRespT     fetchResp;
    logic [ADDR_WIDTH-1:0] ramAddr;
    logic                  ramWe;
    logic [7:0]            ramWdata;
    logic [7:0]            ramRdata;
    logic                  push;
    logic                  pop;
    instPkg::fetchEntryT   pushEntry;
    instPkg::fetchEntryT   head;
    logic                  empty;
    logic                  queueFull;

    memCtrl #(.ADDR_WIDTH(ADDR_WIDTH)) ctrl (.*);

    byteRam #(.ADDR_WIDTH(ADDR_WIDTH)) ram (
        .clk,
        .addr  (ramAddr),
        .we    (ramWe),
        .wdata (ramWdata),
        .rdata (ramRdata)
    );

    fetchUnit #(.START_PC(START_PC)) fetch (.*);

    instQueue #(.QUEUE_DEPTH(QUEUE_DEPTH)) queue (
        .full (queueFull),
        .*
    );

    instDecode decode (.*);

endmodule
